/* common/gb_sys_pkg.sv */
package gb_sys_pkg;

	// ------------------------------------------------------------------------
	// cpu side bus and decoded selects
	// ------------------------------------------------------------------------

	typedef struct packed {
		logic [15:0] addr;   // cpu address
		logic [7:0]  wdata;  // write data from cpu
		logic        rd;     // read strobe, level
		logic        wr;     // write strobe, level
	} cpu_bus_t;

	typedef struct packed {
		logic joy;     // p1 at ff00
		logic if_reg;  // interrupt flags ff0f
		logic ie_reg;  // interrupt enables ffff
		logic svbk;    // wram bank ff70
		logic wram;    // c000-fdff incl echo
		logic hram;    // ff80-fffe
	} sys_sel_t;

	// bit 0 wins on priority
	typedef struct packed {
		logic joypad;
		logic serial;
		logic timer;
		logic lcd;
		logic vblank;
	} irq_bits_t;

	// ------------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------------

	localparam logic [15:0] ADDR_P1   = 16'hff00;
	localparam logic [15:0] ADDR_IF   = 16'hff0f;
	localparam logic [15:0] ADDR_SVBK = 16'hff70;
	localparam logic [15:0] ADDR_IE   = 16'hffff;

	localparam int WRAM_ADDR_W = 15;  // 8 banks of 4k
	localparam int HRAM_ADDR_W = 7;   // 127 bytes used of 128

	// rst vectors, one per source, 8 apart
	localparam logic [7:0] IRQ_VEC_BASE = 8'h40;
	localparam logic [7:0] IRQ_VEC_STEP = 8'h08;
	localparam logic [7:0] IRQ_VEC_NONE = 8'h55;

	localparam logic [7:0] OPEN_BUS = 8'hff;  // nothing drives the bus

endpackage

/* logic/gb_spram.sv */
`timescale 1ns/1ps

// single port ram, registered output
module gb_spram #(
	parameter int addr_w = 8
) (
	input  logic              clk_cpu,
	input  logic [addr_w-1:0] addr,
	input  logic              wren,
	input  logic [7:0]        data,
	output logic [7:0]        q
);

	logic [7:0] mem [2**addr_w];  // no init, contents undefined at power up

	always_ff @(posedge clk_cpu) begin
		if (wren)
			mem[addr] <= data;
		q <= mem[addr];  // old word on a write cycle
	end

endmodule

/* logic/gb_sys_decode.sv */
`timescale 1ns/1ps

// address decode for the system control side
// selects depend on the address only, strobes are qualified in the blocks
module gb_sys_decode (
	input  gb_sys_pkg::cpu_bus_t bus,
	output gb_sys_pkg::sys_sel_t sel
);

	logic in_c000;    // c000-ffff
	logic above_fdff; // fe00-ffff, oam and io
	logic in_ff80;    // ff80-ffff

	assign in_c000    = (bus.addr[15:14] == 2'b11);
	assign above_fdff = &bus.addr[15:9];
	assign in_ff80    = &bus.addr[15:7];

	always_comb begin
		sel = '0;

		// single byte registers
		sel.joy    = (bus.addr == gb_sys_pkg::ADDR_P1);
		sel.if_reg = (bus.addr == gb_sys_pkg::ADDR_IF);
		sel.svbk   = (bus.addr == gb_sys_pkg::ADDR_SVBK);
		sel.ie_reg = (bus.addr == gb_sys_pkg::ADDR_IE);

		// work ram plus its echo, stops short of fe00
		sel.wram = in_c000 && !above_fdff;

		// high ram, last byte is ie
		sel.hram = in_ff80 && (bus.addr != gb_sys_pkg::ADDR_IE);
	end

endmodule

/* logic/gb_joypad.sv */
`timescale 1ns/1ps

module gb_joypad (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  gb_sys_pkg::cpu_bus_t bus,
	input  logic                 sel_joy,
	input  logic [7:0]           buttons,  // right left up down a b select start
	output logic [7:0]           p1_do,
	output logic                 joy_irq
);

	logic [1:0] p54;       // group selects, low active
	logic [3:0] dir_n;     // p14 group
	logic [3:0] act_n;     // p15 group
	logic [3:0] lines;
	logic [3:0] lines_q;

	// pressed button pulls its line low when its group is selected
	assign dir_n = ~buttons[3:0] | {4{p54[0]}};
	assign act_n = ~buttons[7:4] | {4{p54[1]}};
	assign lines = dir_n & act_n;  // wired and of both groups

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54     <= 2'b11;  // nothing selected
			lines_q <= 4'hf;
			joy_irq <= 1'b0;
		end else begin
			if (sel_joy && bus.wr)
				p54 <= bus.wdata[5:4];
			lines_q <= lines;
			joy_irq <= |(lines_q & ~lines);  // any 1 -> 0
		end
	end

	assign p1_do = {2'b11, p54, lines_q};

endmodule

/* interrupts/gb_irq_ctrl.sv */
`timescale 1ns/1ps

module gb_irq_ctrl (
	input  logic                  clk_cpu,
	input  logic                  reset,
	input  gb_sys_pkg::cpu_bus_t  bus,
	input  logic                  sel_if,
	input  logic                  sel_ie,
	input  gb_sys_pkg::irq_bits_t irq_src,
	input  logic                  irq_ack,
	output logic [7:0]            if_do,
	output logic [7:0]            ie_do,
	output logic                  irq_n,
	output logic [7:0]            irq_vec
);

	gb_sys_pkg::irq_bits_t if_r;     // pending flags
	gb_sys_pkg::irq_bits_t ie_r;     // enable mask
	gb_sys_pkg::irq_bits_t src_q;    // last source sample
	gb_sys_pkg::irq_bits_t rise;
	gb_sys_pkg::irq_bits_t if_next;
	logic [4:0]            pend;
	logic [4:0]            lowest;   // one hot, highest priority pending
	logic                  ack_q;
	logic                  ack_fall;

	// ------------------------------------------------------------------------
	// priority and vector
	// ------------------------------------------------------------------------

	assign pend   = if_r & ie_r;
	assign lowest = pend & (~pend + 5'd1);  // isolate lowest set bit
	assign irq_n  = ~|pend;

	always_comb begin
		irq_vec = gb_sys_pkg::IRQ_VEC_NONE;
		// walk down so the lowest index is the last one to hit
		for (int i = 4; i >= 0; i--) begin
			if (pend[i])
				irq_vec = gb_sys_pkg::IRQ_VEC_BASE + gb_sys_pkg::IRQ_VEC_STEP * 8'(i);
		end
	end

	// ------------------------------------------------------------------------
	// flag update
	// ------------------------------------------------------------------------

	assign rise     = irq_src & ~src_q;  // low to high on a source line
	assign ack_fall = ack_q & ~irq_ack;  // ack cycle has just ended

	// set first, then ack takes the serviced bit away
	assign if_next = (if_r | rise) & ~(ack_fall ? lowest : 5'd0);

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r  <= '0;
			ie_r  <= '0;
			src_q <= '0;
			ack_q <= 1'b0;
		end else begin
			src_q <= irq_src;
			ack_q <= irq_ack;

			// cpu write beats both set and ack clear
			if (sel_if && bus.wr)
				if_r <= bus.wdata[4:0];
			else
				if_r <= if_next;

			if (sel_ie && bus.wr)
				ie_r <= bus.wdata[4:0];
		end
	end

	assign if_do = {3'b111, if_r};  // unused bits read high
	assign ie_do = {3'b000, ie_r};

endmodule

/* wram/gb_wram.sv */
`timescale 1ns/1ps

// 32k work ram, d000-dfff switches between banks 1-7 on the colour model
module gb_wram (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  logic                 is_gbc,
	input  gb_sys_pkg::cpu_bus_t bus,
	input  logic                 sel_wram,
	input  logic                 sel_svbk,
	output logic [7:0]           wram_do,
	output logic [7:0]           svbk_do
);

	localparam int bank_w = gb_sys_pkg::WRAM_ADDR_W - 12;

	logic [bank_w-1:0]                 bank;      // svbk, never 0
	logic [bank_w-1:0]                 bank_sel;
	logic [gb_sys_pkg::WRAM_ADDR_W-1:0] phys_addr;
	logic                              wren;

	// ------------------------------------------------------------------------
	// svbk
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			bank <= bank_w'(1);
		end else if (sel_svbk && bus.wr && is_gbc) begin
			if (bus.wdata[bank_w-1:0] == '0)
				bank <= bank_w'(1);  // 0 maps to 1
			else
				bank <= bus.wdata[bank_w-1:0];
		end
	end

	assign svbk_do = is_gbc ? {{(8-bank_w){1'b1}}, bank} : gb_sys_pkg::OPEN_BUS;

	// ------------------------------------------------------------------------
	// address map
	// ------------------------------------------------------------------------

	// upper 4k half is banked, lower half is always bank 0
	// e000-fdff lands on the same bits, hence the echo
	assign bank_sel  = bus.addr[12] ? bank : '0;
	assign phys_addr = {bank_sel, bus.addr[11:0]};
	assign wren      = sel_wram && bus.wr;

	gb_spram #(
		.addr_w (gb_sys_pkg::WRAM_ADDR_W)
	) i_wram (
		.clk_cpu (clk_cpu),
		.addr    (phys_addr),
		.wren    (wren),
		.data    (bus.wdata),
		.q       (wram_do)
	);

endmodule

/* logic/gb_sys_top.sv */
`timescale 1ns/1ps

module gb_sys_top (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  logic                 is_gbc,
	input  gb_sys_pkg::cpu_bus_t bus,
	output logic [7:0]           rdata,
	input  logic [7:0]           buttons,
	input  logic                 vblank_irq,
	input  logic                 lcd_irq,
	input  logic                 timer_irq,
	input  logic                 serial_irq,
	input  logic                 irq_ack,
	output logic                 irq_n,
	output logic [7:0]           irq_vec
);

	gb_sys_pkg::sys_sel_t  sel;
	gb_sys_pkg::irq_bits_t irq_src;
	logic [7:0]            p1_do;
	logic [7:0]            if_do;
	logic [7:0]            ie_do;
	logic [7:0]            wram_do;
	logic [7:0]            svbk_do;
	logic [7:0]            hram_do;
	logic [7:0]            reg_do;     // register side of the read mux
	logic                  joy_irq;
	logic                  hram_wren;
	logic                  ram_rd;
	logic                  wram_rd_q;  // ram read issued last edge
	logic                  hram_rd_q;

	gb_sys_decode i_decode (
		.bus (bus),
		.sel (sel)
	);

	gb_joypad i_joypad (
		.clk_cpu (clk_cpu),
		.reset   (reset),
		.bus     (bus),
		.sel_joy (sel.joy),
		.buttons (buttons),
		.p1_do   (p1_do),
		.joy_irq (joy_irq)
	);

	// ------------------------------------------------------------------------
	// interrupts
	// ------------------------------------------------------------------------

	assign irq_src = '{
		joypad: joy_irq,
		serial: serial_irq,
		timer:  timer_irq,
		lcd:    lcd_irq,
		vblank: vblank_irq
	};

	gb_irq_ctrl i_irq_ctrl (
		.clk_cpu (clk_cpu),
		.reset   (reset),
		.bus     (bus),
		.sel_if  (sel.if_reg),
		.sel_ie  (sel.ie_reg),
		.irq_src (irq_src),
		.irq_ack (irq_ack),
		.if_do   (if_do),
		.ie_do   (ie_do),
		.irq_n   (irq_n),
		.irq_vec (irq_vec)
	);

	// ------------------------------------------------------------------------
	// memories
	// ------------------------------------------------------------------------

	gb_wram i_wram (
		.clk_cpu  (clk_cpu),
		.reset    (reset),
		.is_gbc   (is_gbc),
		.bus      (bus),
		.sel_wram (sel.wram),
		.sel_svbk (sel.svbk),
		.wram_do  (wram_do),
		.svbk_do  (svbk_do)
	);

	assign hram_wren = sel.hram && bus.wr;

	gb_spram #(
		.addr_w (gb_sys_pkg::HRAM_ADDR_W)
	) i_hram (
		.clk_cpu (clk_cpu),
		.addr    (bus.addr[gb_sys_pkg::HRAM_ADDR_W-1:0]),
		.wren    (hram_wren),
		.data    (bus.wdata),
		.q       (hram_do)
	);

	// ------------------------------------------------------------------------
	// read mux
	// ------------------------------------------------------------------------

	always_comb begin
		if (sel.joy)
			reg_do = p1_do;
		else if (sel.if_reg)
			reg_do = if_do;
		else if (sel.ie_reg)
			reg_do = ie_do;
		else if (sel.svbk)
			reg_do = svbk_do;
		else
			reg_do = gb_sys_pkg::OPEN_BUS;  // unmapped
	end

	assign ram_rd = bus.rd && (sel.wram || sel.hram);

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			rdata     <= gb_sys_pkg::OPEN_BUS;
			wram_rd_q <= 1'b0;
			hram_rd_q <= 1'b0;
		end else begin
			wram_rd_q <= bus.rd && sel.wram;
			hram_rd_q <= bus.rd && sel.hram;

			// ram q is only there one edge after the address
			if (wram_rd_q)
				rdata <= wram_do;
			else if (hram_rd_q)
				rdata <= hram_do;

			// registers land on the rd edge itself, newer read wins
			if (bus.rd && !ram_rd)
				rdata <= reg_do;
		end
	end

endmodule

/* tests/gb_sys_tests.svh */
// ----------------------------------------------------------------------------
// wait and ack helpers
// ----------------------------------------------------------------------------

task automatic wait_irq(input logic level, input int limit, input string what);
	int n;
	n = 0;
	while (irq_n !== level && n < limit) begin
		@(negedge clk_cpu);
		n++;
	end
	checks++;
	assert (irq_n === level)
	else begin
		errors++;
		$display("timeout after %0d cycles waiting for %s", limit, what);
	end
endtask

task automatic wait_vec_change(input logic [7:0] old, input int limit, input string what);
	int n;
	n = 0;
	while (irq_vec === old && n < limit) begin
		@(negedge clk_cpu);
		n++;
	end
	checks++;
	assert (irq_vec !== old)
	else begin
		errors++;
		$display("timeout after %0d cycles waiting for %s", limit, what);
	end
endtask

// irq_n must stay high for the whole window
task automatic watch_no_irq(input int cycles, input string what);
	logic seen;
	seen = 1'b0;
	for (int n = 0; n < cycles; n++) begin
		@(negedge clk_cpu);
		seen = seen | ~irq_n;
	end
	checks++;
	assert (!seen)
	else begin
		errors++;
		$display("irq_n went low although no interrupt was expected (%s)", what);
	end
endtask

task automatic pulse_ack();
	irq_ack = 1'b1;
	@(negedge clk_cpu);
	irq_ack = 1'b0;
endtask

// ----------------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------------

task automatic wram_banking();
	logic [7:0] b0, b1, b3, b7, d;
	int         start;
	start  = errors;
	is_gbc = 1'b1;
	rand_byte(b0);
	rand_byte(b1);
	rand_byte(b3);
	rand_byte(b7);
	write_byte(gb_sys_pkg::ADDR_SVBK, 8'd1);
	write_byte(16'hd123, b1);
	write_byte(gb_sys_pkg::ADDR_SVBK, 8'd3);
	write_byte(16'hd123, b3);
	write_byte(gb_sys_pkg::ADDR_SVBK, 8'd7);
	write_byte(16'hd123, b7);
	write_byte(16'hc123, b0);  // fixed bank 0 half
	write_byte(gb_sys_pkg::ADDR_SVBK, 8'd1);
	read_byte(16'hd123, d);
	check_byte("wram d123 bank 1", d, b1);
	write_byte(gb_sys_pkg::ADDR_SVBK, 8'd3);
	read_byte(16'hd123, d);
	check_byte("wram d123 bank 3", d, b3);
	write_byte(gb_sys_pkg::ADDR_SVBK, 8'd7);
	read_byte(16'hd123, d);
	check_byte("wram d123 bank 7", d, b7);
	read_byte(16'hc123, d);
	check_byte("wram c123", d, b0);
	read_byte(16'he123, d);  // echo of c123
	check_byte("echo e123", d, b0);
	read_byte(16'hf123, d);  // echo of d123 with bank 7 still set
	check_byte("echo f123", d, b7);
	// bank 0 is stored as 1
	write_byte(gb_sys_pkg::ADDR_SVBK, 8'd0);
	read_byte(gb_sys_pkg::ADDR_SVBK, d);
	check_byte("svbk after 0", d, {5'b11111, 3'd1});
	// dmg mode ignores svbk
	is_gbc = 1'b0;
	write_byte(gb_sys_pkg::ADDR_SVBK, 8'd3);
	read_byte(gb_sys_pkg::ADDR_SVBK, d);
	check_byte("svbk dmg", d, 8'hff);
	read_byte(16'hd123, d);
	check_byte("wram d123 dmg", d, b1);
	is_gbc = 1'b1;
	read_byte(gb_sys_pkg::ADDR_SVBK, d);
	check_byte("svbk kept", d, {5'b11111, 3'd1});
	report_test("wram banking", start);
endtask

task automatic hram_access();
	logic [15:0] addrs [3];
	logic [7:0]  vals [3];
	logic [7:0]  d;
	int          start;
	start = errors;
	addrs = '{16'hff80, 16'hffc0, 16'hfffe};
	for (int i = 0; i < 3; i++) begin
		rand_byte(vals[i]);
		write_byte(addrs[i], vals[i]);
	end
	for (int i = 0; i < 3; i++) begin
		read_byte(addrs[i], d);
		check_byte($sformatf("hram %04h", addrs[i]), d, vals[i]);
	end
	read_byte(16'hfe00, d);  // oam space is unmapped here
	check_byte("open bus fe00", d, 8'hff);
	read_byte(16'hff7f, d);
	check_byte("open bus ff7f", d, 8'hff);
	report_test("high ram", start);
endtask

task automatic ie_if_regs();
	logic [7:0] a, b, d;
	int         start;
	start = errors;
	apply_reset();
	read_byte(gb_sys_pkg::ADDR_IE, d);
	check_byte("ie after reset", d, 8'h00);
	read_byte(gb_sys_pkg::ADDR_IF, d);
	check_byte("if after reset", d, 8'he0);
	check_bit("irq_n after reset", irq_n, 1'b1);
	for (int i = 0; i < 6; i++) begin
		rand_byte(a);
		rand_byte(b);
		if (i == 4) begin
			a = 8'h05;  // disjoint masks
			b = 8'h0a;
		end else if (i == 5) begin
			a = 8'h05;
			b = 8'h04;
		end
		write_byte(gb_sys_pkg::ADDR_IE, a);
		write_byte(gb_sys_pkg::ADDR_IF, b);
		read_byte(gb_sys_pkg::ADDR_IE, d);
		check_byte("ie readback", d, {3'b000, a[4:0]});
		read_byte(gb_sys_pkg::ADDR_IF, d);
		check_byte("if readback", d, {3'b111, b[4:0]});
		check_bit("irq_n", irq_n, ~|(a[4:0] & b[4:0]));
	end
	write_byte(gb_sys_pkg::ADDR_IF, 8'h00);
	write_byte(gb_sys_pkg::ADDR_IE, 8'h00);
	report_test("ie and if registers", start);
endtask

task automatic irq_priority_ack();
	logic [7:0] d;
	int         start;
	start = errors;
	write_byte(gb_sys_pkg::ADDR_IF, 8'h00);
	write_byte(gb_sys_pkg::ADDR_IE, 8'h1f);
	timer_irq = 1'b1;
	lcd_irq   = 1'b1;
	wait_irq(1'b0, 20, "irq_n low after lcd and timer");
	check_byte("irq_vec lcd", irq_vec, 8'h48);
	pulse_ack();
	wait_vec_change(8'h48, 10, "vector change after first ack");
	check_byte("irq_vec timer", irq_vec, 8'h50);
	read_byte(gb_sys_pkg::ADDR_IF, d);
	check_byte("if after first ack", d, {3'b111, 5'b00100});
	pulse_ack();
	wait_irq(1'b1, 10, "irq_n high after second ack");
	check_byte("irq_vec none", irq_vec, 8'h55);
	timer_irq = 1'b0;
	lcd_irq   = 1'b0;
	write_byte(gb_sys_pkg::ADDR_IE, 8'h00);
	report_test("interrupt priority and ack", start);
endtask

task automatic joypad_lines();
	logic [7:0] d;
	int         start;
	start = errors;
	write_byte(gb_sys_pkg::ADDR_IF, 8'h00);
	write_byte(gb_sys_pkg::ADDR_IE, 8'h10);  // joypad only
	write_byte(gb_sys_pkg::ADDR_P1, 8'h20);  // direction group
	buttons = 8'h08;                          // down
	wait_irq(1'b0, 20, "joypad interrupt");
	read_byte(gb_sys_pkg::ADDR_P1, d);
	check_byte("p1 down", d, {2'b11, 2'b10, 4'b0111});
	read_byte(gb_sys_pkg::ADDR_IF, d);
	check_bit("if joypad", d[4], 1'b1);
	buttons = 8'h00;  // release is a rise so no flag
	write_byte(gb_sys_pkg::ADDR_IF, 8'h00);
	write_byte(gb_sys_pkg::ADDR_P1, 8'h30);  // no group
	buttons = 8'h18;
	watch_no_irq(16, "no group selected");
	read_byte(gb_sys_pkg::ADDR_P1, d);
	check_byte("p1 deselected", d, {2'b11, 2'b11, 4'b1111});
	read_byte(gb_sys_pkg::ADDR_IF, d);
	check_byte("if deselected", d, 8'he0);
	buttons = 8'h00;
	write_byte(gb_sys_pkg::ADDR_IE, 8'h00);
	report_test("joypad", start);
endtask

/* tests/gb_sys_tb.sv */
`timescale 1ns/1ps

module gb_sys_tb;

	logic                 clk_cpu;
	logic                 reset;
	logic                 is_gbc;
	gb_sys_pkg::cpu_bus_t bus;
	logic [7:0]           rdata;
	logic [7:0]           buttons;   // right left up down a b select start
	logic                 vblank_irq;
	logic                 lcd_irq;
	logic                 timer_irq;
	logic                 serial_irq;
	logic                 irq_ack;
	logic                 irq_n;
	logic [7:0]           irq_vec;

	int          checks;
	int          errors;
	logic [15:0] lfsr;   // random state

	always #10 clk_cpu = ~clk_cpu;  // 20 ns period

	gb_sys_top i_gb_sys_top (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.is_gbc     (is_gbc),
		.bus        (bus),
		.rdata      (rdata),
		.buttons    (buttons),
		.vblank_irq (vblank_irq),
		.lcd_irq    (lcd_irq),
		.timer_irq  (timer_irq),
		.serial_irq (serial_irq),
		.irq_ack    (irq_ack),
		.irq_n      (irq_n),
		.irq_vec    (irq_vec)
	);

	// ------------------------------------------------------------------------
	// fibonacci lfsr over x^16 + x^14 + x^13 + x^11 + 1
	// ------------------------------------------------------------------------

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// one step per bit
	task automatic rand_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b    = {b[6:0], lfsr[0]};
		end
	endtask

	// ------------------------------------------------------------------------
	// bus tasks that all return on a falling edge
	// ------------------------------------------------------------------------

	task automatic apply_reset();
		reset = 1'b1;
		repeat (8) @(posedge clk_cpu);
		@(negedge clk_cpu);
		reset = 1'b0;
	endtask

	task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
		bus.addr  = addr;
		bus.wdata = data;
		bus.wr    = 1'b1;
		@(negedge clk_cpu);  // write lands on the rising edge in between
		bus.wr = 1'b0;
	endtask

	// sampled one edge after the rd edge where ram and register data are both valid
	task automatic read_byte(input logic [15:0] addr, output logic [7:0] data);
		bus.addr = addr;
		bus.rd   = 1'b1;
		@(negedge clk_cpu);
		bus.rd = 1'b0;
		@(negedge clk_cpu);
		data = rdata;
	endtask

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	task automatic check_byte(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("FAILED t=%0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errs_before);
	endtask

	`include "gb_sys_tests.svh"

	initial begin
		clk_cpu    = 1'b0;
		reset      = 1'b1;
		is_gbc     = 1'b0;
		bus        = '0;
		buttons    = '0;
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;
		serial_irq = 1'b0;
		irq_ack    = 1'b0;
		lfsr       = 16'd23;
		checks     = 0;
		errors     = 0;

		apply_reset();

		wram_banking();
		hram_access();
		ie_if_regs();
		irq_priority_ack();
		joypad_lines();

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* gb_sys_top.f */
+incdir+tests
common/gb_sys_pkg.sv
logic/gb_spram.sv
logic/gb_sys_decode.sv
logic/gb_joypad.sv
interrupts/gb_irq_ctrl.sv
wram/gb_wram.sv
logic/gb_sys_top.sv
tests/gb_sys_tb.sv
